// File: processorci_top.f
verilog/processorci_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/cmd_controller.sv
verilog/wb_memory.sv
verilog/acc_core.sv
verilog/processorci_top.sv
test/processorci_tb.sv

// File: test/processorci_tb.sv
`default_nettype none

module processorci_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import processorci_pkg::*;

    localparam int REPLY_TIMEOUT = 20000;  // Cycles to wait for a start bit
    localparam int LCG_WORDS     = 16;

    logic sys_clk = 1'b0;
    logic rst_n_i;
    logic rx_i;
    logic tx_o;
    logic core_halted_o;

    logic [7:0]  send_buf [0:7];
    logic [7:0]  exp_buf [0:7];
    logic [31:0] model_mem [0:63];  // Last value written per address
    logic [5:0]  lcg_addr [0:LCG_WORDS-1];
    logic [31:0] lcg_state;
    int          check_cnt;
    int          script_cnt;

    processorci_top dut (
        .sys_clk_i     (sys_clk),
        .rst_n_i       (rst_n_i),
        .rx_i          (rx_i),
        .tx_o          (tx_o),
        .core_halted_o (core_halted_o)
    );

    always #10 sys_clk = ~sys_clk;

    task automatic end_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        check_cnt++;
        if (expected !== actual) begin
            $display("ERR at time %0t: %0s, expected %0h, got %0h", $time, what, expected, actual);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            rx_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
    endtask

    task automatic receive_byte(output logic [7:0] b, input string what);
        int waited;
        int i;
        waited = 0;
        b = '0;
        @(negedge sys_clk);
        while (tx_o !== 1'b0 && waited < REPLY_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (tx_o !== 1'b0) begin
            $display("Timeout: %0s never came from the DUT", what);
            end_with_failure();
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // Middle of start bit
            check_value(0, tx_o, {what, " start bit"});
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                b[i] = tx_o;
            end
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            check_value(1, tx_o, {what, " stop bit"});
        end
    endtask

    // One command, then its whole reply
    task automatic do_transaction(input int n_send, input int n_exp, input string tag);
        logic [7:0] got;
        int i;
        for (i = 0; i < n_send; i++) begin
            send_byte(send_buf[i]);
        end
        for (i = 0; i < n_exp; i++) begin
            receive_byte(got, $sformatf("%0s reply byte %0d", tag, i));
            check_value(exp_buf[i], got, $sformatf("%0s reply byte %0d", tag, i));
        end
    endtask

    task automatic run_script(input int fd, input logic [8*16-1:0] mnem);
        int n_send;
        int n_exp;
        int i;
        int code;
        string tag;
        tag = $sformatf("%0s line %0d", mnem, script_cnt);
        n_exp = 0;
        code = $fscanf(fd, "%d", n_send);
        for (i = 0; i < n_send && i < 8; i++) begin
            code = $fscanf(fd, "%h", send_buf[i]);
        end
        code = $fscanf(fd, "%d", n_exp);
        if (code != 1 || n_send < 1 || n_send > 8 || n_exp < 1 || n_exp > 8) begin
            $display("The test file has a malformed script: %0s", tag);
            end_with_failure();
        end else begin
            for (i = 0; i < n_exp; i++) begin
                code = $fscanf(fd, "%h", exp_buf[i]);
            end
            do_transaction(n_send, n_exp, tag);
            @(negedge sys_clk);
            if (mnem == "RUN") begin
                check_value(1, core_halted_o, {tag, " halted after run"});
            end else if (mnem == "HOLD") begin
                check_value(0, core_halted_o, {tag, " halted after hold"});
            end
            script_cnt++;
        end
    endtask

    task automatic write_word(input logic [5:0] addr, input logic [31:0] data, input string tag);
        send_buf[0] = CMD_WRITE;
        send_buf[1] = {2'b00, addr};
        send_buf[2] = data[7:0];
        send_buf[3] = data[15:8];
        send_buf[4] = data[23:16];
        send_buf[5] = data[31:24];
        exp_buf[0]  = REPLY_OK;
        do_transaction(6, 1, tag);
    endtask

    task automatic read_word(input logic [5:0] addr, input logic [31:0] expected,
                             input string tag);
        send_buf[0] = CMD_READ;
        send_buf[1] = {2'b00, addr};
        exp_buf[0]  = expected[7:0];
        exp_buf[1]  = expected[15:8];
        exp_buf[2]  = expected[23:16];
        exp_buf[3]  = expected[31:24];
        do_transaction(2, 4, tag);
    endtask

    initial begin
        int fd;
        int code;
        int k;
        logic done;
        logic [8*16-1:0]  mnem;
        logic [8*200-1:0] rest;

        rst_n_i    = 1'b0;
        rx_i       = 1'b1;   // Serial line idles high
        check_cnt  = 0;
        script_cnt = 0;
        lcg_state  = 32'd98;
        repeat (16) @(posedge sys_clk);
        rst_n_i <= 1'b1;

        // Quiet line and no halt before any command
        for (k = 0; k < 200; k++) begin
            @(negedge sys_clk);
            check_value(1, tx_o, "tx line idle after reset");
            check_value(0, core_halted_o, "halted low after reset");
        end

        fd = $fopen("test/processorci_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file test/processorci_tests.txt");
            end_with_failure();
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", mnem);
            if (code != 1) begin
                done = 1'b1;
            end else if (mnem == "#") begin
                code = $fgets(rest, fd);   // Comment line
            end else begin
                run_script(fd, mnem);
            end
        end
        $fclose(fd);

        // Random words while the core is held
        for (k = 0; k < LCG_WORDS; k++) begin
            lcg_state   = lcg_next(lcg_state);
            lcg_addr[k] = lcg_state[13:8];
            lcg_state   = lcg_next(lcg_state);
            model_mem[lcg_addr[k]] = lcg_state;
            write_word(lcg_addr[k], lcg_state, $sformatf("random write %0d", k));
        end
        for (k = 0; k < LCG_WORDS; k++) begin
            read_word(lcg_addr[k], model_mem[lcg_addr[k]], $sformatf("random read %0d", k));
        end

        $display("%0d scripts, %0d random words, %0d checks", script_cnt, LCG_WORDS, check_cnt);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/processorci_tests.txt
# mnemonic, number of bytes sent, sent bytes in hex,
# number of reply bytes, expected reply bytes in hex
ID   1 05 1 5A
BAD  1 FF 1 EE
BAD  1 00 1 EE
# LDA 20, ADD 21, SUB 22, STA 23, HALT
WR   6 01 00 20 00 00 01 1 AA
WR   6 01 01 21 00 00 02 1 AA
WR   6 01 02 22 00 00 03 1 AA
WR   6 01 03 23 00 00 04 1 AA
WR   6 01 04 00 00 00 07 1 AA
WR   6 01 20 78 56 34 12 1 AA
WR   6 01 21 00 00 00 F0 1 AA
WR   6 01 22 79 06 00 00 1 AA
RD   2 02 20 4 78 56 34 12
RD   2 02 21 4 00 00 00 F0
RD   2 02 03 4 23 00 00 04
RUN  1 03 1 AA
HOLD 1 04 1 AA
# 12345678 + F0000000 wraps to 02345678, minus 679 gives 02344FFF
RD   2 02 23 4 FF 4F 34 02
# Countdown from 7 at 30, step 1 at 31, pass count at 32
WR   6 01 00 32 00 00 01 1 AA
WR   6 01 01 31 00 00 02 1 AA
WR   6 01 02 32 00 00 04 1 AA
WR   6 01 03 30 00 00 01 1 AA
WR   6 01 04 31 00 00 03 1 AA
WR   6 01 05 30 00 00 04 1 AA
WR   6 01 06 08 00 00 06 1 AA
WR   6 01 07 00 00 00 07 1 AA
WR   6 01 08 00 00 00 05 1 AA
WR   6 01 30 07 00 00 00 1 AA
WR   6 01 31 01 00 00 00 1 AA
WR   6 01 32 00 00 00 00 1 AA
RUN  1 03 1 AA
BUSY 1 01 1 EE
BUSY 1 02 1 EE
HOLD 1 04 1 AA
RD   2 02 30 4 00 00 00 00
RD   2 02 32 4 07 00 00 00
RD   2 02 31 4 01 00 00 00

// File: verilog/acc_core.sv
`default_nettype none

module acc_core (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               run_i,
    output logic                               bus_cyc_o,
    output logic                               bus_stb_o,
    output logic                               bus_we_o,
    output logic [processorci_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [processorci_pkg::WORD_W-1:0] bus_wdata_o,
    input  logic [processorci_pkg::WORD_W-1:0] bus_rdata_i,
    input  logic                               bus_ack_i,
    output logic                               halted_o
);
    import processorci_pkg::*;

    core_state_e       state_q;
    logic [ADDR_W-1:0] pc_q;
    logic [WORD_W-1:0] ir_q;
    logic [WORD_W-1:0] acc_q;
    logic              core_rst_n;
    core_op_e          op;
    logic              mem_op;

    assign core_rst_n = rst_n_i && run_i;  // Held in reset while not running
    assign op         = core_op_e'(ir_q[WORD_W-1 -: 8]);
    assign mem_op     = (op == OP_LDA) || (op == OP_ADD) || (op == OP_SUB) || (op == OP_STA);

    // Data access starts in DECODE so memory ops take two cycles after fetch
    always_comb begin
        bus_cyc_o  = 1'b0;
        bus_we_o   = 1'b0;
        bus_addr_o = pc_q;
        case (state_q)
            FETCH: bus_cyc_o = core_rst_n;  // Bus idle while held in reset
            DECODE: begin
                bus_cyc_o  = mem_op;
                bus_we_o   = (op == OP_STA);
                bus_addr_o = ir_q[ADDR_W-1:0];
            end
            MEM_READ: begin
                bus_cyc_o  = 1'b1;
                bus_addr_o = ir_q[ADDR_W-1:0];
            end
            MEM_WRITE: begin
                bus_cyc_o  = 1'b1;
                bus_we_o   = 1'b1;
                bus_addr_o = ir_q[ADDR_W-1:0];
            end
            default: ;
        endcase
    end

    assign bus_stb_o   = bus_cyc_o;
    assign bus_wdata_o = acc_q;
    assign halted_o    = (state_q == HALTED);

    always_ff @(posedge clk_i) begin
        if (!core_rst_n) begin
            state_q <= FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                FETCH: begin
                    if (bus_ack_i) begin
                        ir_q    <= bus_rdata_i;
                        pc_q    <= pc_q + 1'b1;
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    case (op)
                        OP_LDA, OP_ADD, OP_SUB: state_q <= MEM_READ;
                        OP_STA: state_q <= MEM_WRITE;
                        OP_JMP: begin
                            pc_q    <= ir_q[ADDR_W-1:0];
                            state_q <= FETCH;
                        end
                        OP_BNZ: begin
                            if (acc_q != '0) begin
                                pc_q <= ir_q[ADDR_W-1:0];
                            end
                            state_q <= FETCH;
                        end
                        OP_HALT: state_q <= HALTED;
                        default: state_q <= HALTED;  // Unknown opcode
                    endcase
                end
                MEM_READ: begin
                    if (bus_ack_i) begin
                        case (op)
                            OP_LDA:  acc_q <= bus_rdata_i;
                            OP_ADD:  acc_q <= acc_q + bus_rdata_i;
                            OP_SUB:  acc_q <= acc_q - bus_rdata_i;
                            default: acc_q <= acc_q;
                        endcase
                        state_q <= FETCH;
                    end
                end
                MEM_WRITE: begin
                    if (bus_ack_i) begin
                        state_q <= FETCH;
                    end
                end
                default: state_q <= HALTED;  // Stays here until run drops
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/cmd_controller.sv
`default_nettype none

module cmd_controller (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [7:0]                         rx_data_i,
    input  logic                               rx_valid_i,
    output logic [7:0]                         tx_data_o,
    output logic                               tx_start_o,
    input  logic                               tx_busy_i,
    output logic                               ctl_stb_o,
    output logic                               ctl_we_o,
    output logic [processorci_pkg::ADDR_W-1:0] ctl_addr_o,
    output logic [processorci_pkg::WORD_W-1:0] ctl_wdata_o,
    input  logic [processorci_pkg::WORD_W-1:0] ctl_rdata_i,
    input  logic                               ctl_ack_i,
    output logic                               core_run_o,
    input  logic                               core_halted_i
);
    import processorci_pkg::*;

    ctrl_state_e       state_q;
    cmd_e              cmd_q;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] data_q;
    logic [1:0]        byte_cnt_q;
    logic [WORD_W-1:0] reply_q;      // Next reply byte in the low byte
    logic [2:0]        reply_cnt_q;  // Reply bytes still to send
    logic              stb_q;
    logic              run_q;
    logic              send_now;

    // Busy rises the cycle after a start, so no extra guard is needed
    assign send_now   = (state_q == SEND) && (reply_cnt_q != 3'd0) && !tx_busy_i;
    assign tx_start_o = send_now;
    assign tx_data_o  = reply_q[7:0];

    assign ctl_stb_o   = stb_q;
    assign ctl_we_o    = (cmd_q == CMD_WRITE);
    assign ctl_addr_o  = addr_q;
    assign ctl_wdata_o = data_q;
    assign core_run_o  = run_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            cmd_q       <= CMD_ID;
            byte_cnt_q  <= '0;
            reply_cnt_q <= '0;
            stb_q       <= 1'b0;
            run_q       <= 1'b0;
        end else begin
            stb_q <= 1'b0;  // Single-cycle strobe
            case (state_q)
                IDLE: begin
                    if (rx_valid_i) begin
                        cmd_q       <= cmd_e'(rx_data_i);
                        reply_cnt_q <= 3'd1;
                        state_q     <= SEND;
                        case (cmd_e'(rx_data_i))
                            CMD_WRITE, CMD_READ: begin
                                if (run_q) begin
                                    reply_q <= WORD_W'(REPLY_BAD);  // Core owns the bus
                                end else begin
                                    state_q <= GET_ADDR;
                                end
                            end
                            CMD_RUN: begin
                                run_q   <= 1'b1;
                                state_q <= WAIT_HALT;
                            end
                            CMD_HOLD: begin
                                run_q   <= 1'b0;
                                reply_q <= WORD_W'(REPLY_OK);
                            end
                            CMD_ID:  reply_q <= WORD_W'(HARNESS_ID);
                            default: reply_q <= WORD_W'(REPLY_BAD);
                        endcase
                    end
                end
                GET_ADDR: begin
                    if (rx_valid_i) begin
                        addr_q     <= rx_data_i[ADDR_W-1:0];
                        byte_cnt_q <= '0;
                        if (cmd_q == CMD_WRITE) begin
                            state_q <= GET_DATA;
                        end else begin
                            stb_q   <= 1'b1;
                            state_q <= MEM_ACCESS;
                        end
                    end
                end
                GET_DATA: begin
                    if (rx_valid_i) begin
                        data_q     <= {rx_data_i, data_q[WORD_W-1:8]};  // LSB first
                        byte_cnt_q <= byte_cnt_q + 2'd1;
                        if (byte_cnt_q == 2'd3) begin
                            stb_q   <= 1'b1;
                            state_q <= MEM_ACCESS;
                        end
                    end
                end
                MEM_ACCESS: begin
                    if (ctl_ack_i) begin
                        if (cmd_q == CMD_WRITE) begin
                            reply_q     <= WORD_W'(REPLY_OK);
                            reply_cnt_q <= 3'd1;
                        end else begin
                            reply_q     <= ctl_rdata_i;
                            reply_cnt_q <= 3'd4;
                        end
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    if (send_now) begin
                        reply_q     <= reply_q >> 8;
                        reply_cnt_q <= reply_cnt_q - 3'd1;
                    end else if (reply_cnt_q == 3'd0) begin
                        state_q <= IDLE;
                    end
                end
                WAIT_HALT: begin
                    // Core was in reset until now, so halted starts low
                    if (core_halted_i) begin
                        reply_q     <= WORD_W'(REPLY_OK);
                        reply_cnt_q <= 3'd1;
                        state_q     <= SEND;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/processorci_pkg.sv
`default_nettype none

package processorci_pkg;

    // Bus geometry
    localparam int WORD_W = 32;
    localparam int ADDR_W = 6;    // 64 words

    // Serial timing
    localparam int CLKS_PER_BIT = 16;
    localparam int DIV_W        = $clog2(CLKS_PER_BIT);

    // Reply bytes
    localparam logic [7:0] HARNESS_ID = 8'h5A;
    localparam logic [7:0] REPLY_OK   = 8'hAA;
    localparam logic [7:0] REPLY_BAD  = 8'hEE;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h01,
        CMD_READ  = 8'h02,
        CMD_RUN   = 8'h03,
        CMD_HOLD  = 8'h04,
        CMD_ID    = 8'h05
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        GET_ADDR,
        GET_DATA,
        MEM_ACCESS,
        SEND,
        WAIT_HALT
    } ctrl_state_e;

    // Opcode sits in the top byte of the instruction word
    typedef enum logic [7:0] {
        OP_LDA  = 8'h01,
        OP_ADD  = 8'h02,
        OP_SUB  = 8'h03,
        OP_STA  = 8'h04,
        OP_JMP  = 8'h05,
        OP_BNZ  = 8'h06,
        OP_HALT = 8'h07
    } core_op_e;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        MEM_READ,
        MEM_WRITE,
        HALTED
    } core_state_e;

endpackage

`default_nettype wire

// File: verilog/processorci_top.sv
`default_nettype none

module processorci_top (
    input  logic sys_clk_i,
    input  logic rst_n_i,
    input  logic rx_i,
    output logic tx_o,
    output logic core_halted_o    // Lets a harness watch the core
);
    import processorci_pkg::*;

    // Serial link
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    // Controller port
    logic              ctl_stb;
    logic              ctl_we;
    logic [ADDR_W-1:0] ctl_addr;
    logic [WORD_W-1:0] ctl_wdata;
    logic [WORD_W-1:0] ctl_rdata;
    logic              ctl_ack;

    // Core bus
    logic              core_run;
    logic              core_cyc;
    logic              core_stb;
    logic              core_we;
    logic [ADDR_W-1:0] core_addr;
    logic [WORD_W-1:0] core_wdata;
    logic [WORD_W-1:0] core_rdata;
    logic              core_ack;

    uart_rx u_uart_rx (
        .clk_i      (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    uart_tx u_uart_tx (
        .clk_i      (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .tx_data_i  (tx_data),
        .tx_start_i (tx_start),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

    cmd_controller u_cmd_controller (
        .clk_i         (sys_clk_i),
        .rst_n_i       (rst_n_i),
        .rx_data_i     (rx_data),
        .rx_valid_i    (rx_valid),
        .tx_data_o     (tx_data),
        .tx_start_o    (tx_start),
        .tx_busy_i     (tx_busy),
        .ctl_stb_o     (ctl_stb),
        .ctl_we_o      (ctl_we),
        .ctl_addr_o    (ctl_addr),
        .ctl_wdata_o   (ctl_wdata),
        .ctl_rdata_i   (ctl_rdata),
        .ctl_ack_i     (ctl_ack),
        .core_run_o    (core_run),
        .core_halted_i (core_halted_o)
    );

    wb_memory u_wb_memory (
        .clk_i        (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .core_run_i   (core_run),
        .ctl_stb_i    (ctl_stb),
        .ctl_we_i     (ctl_we),
        .ctl_addr_i   (ctl_addr),
        .ctl_wdata_i  (ctl_wdata),
        .ctl_rdata_o  (ctl_rdata),
        .ctl_ack_o    (ctl_ack),
        .core_cyc_i   (core_cyc),
        .core_stb_i   (core_stb),
        .core_we_i    (core_we),
        .core_addr_i  (core_addr),
        .core_wdata_i (core_wdata),
        .core_rdata_o (core_rdata),
        .core_ack_o   (core_ack)
    );

    acc_core u_acc_core (
        .clk_i       (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .run_i       (core_run),
        .bus_cyc_o   (core_cyc),
        .bus_stb_o   (core_stb),
        .bus_we_o    (core_we),
        .bus_addr_o  (core_addr),
        .bus_wdata_o (core_wdata),
        .bus_rdata_i (core_rdata),
        .bus_ack_i   (core_ack),
        .halted_o    (core_halted_o)
    );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);
    import processorci_pkg::*;

    logic [1:0]       sync_q;     // Two-flop synchronizer
    logic             rx_s;
    logic             busy_q;
    logic [3:0]       bit_cnt_q;  // 0 start, 1..8 data, 9 stop
    logic [DIV_W-1:0] div_q;
    logic [7:0]       shift_q;
    logic             sample;

    assign rx_s   = sync_q[1];
    assign sample = busy_q && (div_q == '0);

    // Good frame only when the stop bit reads high
    assign rx_valid_o = sample && (bit_cnt_q == 4'd9) && rx_s;
    assign rx_data_o  = shift_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync_q    <= 2'b11;
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            div_q     <= '0;
        end else begin
            sync_q <= {sync_q[0], rx_i};
            if (!busy_q) begin
                if (!rx_s) begin
                    busy_q    <= 1'b1;
                    bit_cnt_q <= '0;
                    div_q     <= DIV_W'(CLKS_PER_BIT / 2 - 1);  // Aim at mid start bit
                end
            end else if (sample) begin
                div_q <= DIV_W'(CLKS_PER_BIT - 1);
                if (bit_cnt_q == 4'd0 && rx_s) begin
                    busy_q <= 1'b0;               // Glitch, not a start bit
                end else if (bit_cnt_q == 4'd9) begin
                    busy_q <= 1'b0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end else begin
                div_q <= div_q - 1'b1;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk_i) begin
        if (sample && bit_cnt_q != 4'd0 && bit_cnt_q != 4'd9) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_start_i,
    output logic       tx_o,
    output logic       tx_busy_o
);
    import processorci_pkg::*;

    logic [9:0]       shift_q;   // Stop, data, start
    logic [3:0]       bit_cnt_q;
    logic [DIV_W-1:0] div_q;
    logic             busy_q;

    assign tx_busy_o = busy_q;
    assign tx_o      = !busy_q || shift_q[0];  // Line idles high

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            div_q     <= '0;
        end else if (!busy_q) begin
            if (tx_start_i) begin
                busy_q    <= 1'b1;
                bit_cnt_q <= '0;
                div_q     <= DIV_W'(CLKS_PER_BIT - 1);
            end
        end else if (div_q == '0) begin
            div_q <= DIV_W'(CLKS_PER_BIT - 1);
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;      // Stop bit done
            end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else begin
            div_q <= div_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_q && tx_start_i) begin
            shift_q <= {1'b1, tx_data_i, 1'b0};
        end else if (busy_q && div_q == '0) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_memory.sv
`default_nettype none

module wb_memory (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               core_run_i,
    input  logic                               ctl_stb_i,
    input  logic                               ctl_we_i,
    input  logic [processorci_pkg::ADDR_W-1:0] ctl_addr_i,
    input  logic [processorci_pkg::WORD_W-1:0] ctl_wdata_i,
    output logic [processorci_pkg::WORD_W-1:0] ctl_rdata_o,
    output logic                               ctl_ack_o,
    input  logic                               core_cyc_i,
    input  logic                               core_stb_i,
    input  logic                               core_we_i,
    input  logic [processorci_pkg::ADDR_W-1:0] core_addr_i,
    input  logic [processorci_pkg::WORD_W-1:0] core_wdata_i,
    output logic [processorci_pkg::WORD_W-1:0] core_rdata_o,
    output logic                               core_ack_o
);
    import processorci_pkg::*;

    logic [WORD_W-1:0] mem [0:(1 << ADDR_W) - 1];
    logic              sel_core_q;  // Port that owns the pending ack
    logic              ack_q;
    logic [WORD_W-1:0] rdata_q;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;

    // Port select follows core run state
    assign stb   = core_run_i ? (core_cyc_i && core_stb_i) : ctl_stb_i;
    assign we    = core_run_i ? core_we_i : ctl_we_i;
    assign addr  = core_run_i ? core_addr_i : ctl_addr_i;
    assign wdata = core_run_i ? core_wdata_i : ctl_wdata_i;

    assign ctl_ack_o    = ack_q && !sel_core_q;
    assign core_ack_o   = ack_q && sel_core_q;
    assign ctl_rdata_o  = rdata_q;
    assign core_rdata_o = rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_core_q <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            sel_core_q <= core_run_i;
            if (core_run_i != sel_core_q) begin
                ack_q <= 1'b0;               // Drop ack on a port switch
            end else begin
                ack_q <= stb && !ack_q;      // One ack per held strobe
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stb && !ack_q) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata_q <= mem[addr];
        end
    end

endmodule

`default_nettype wire
